// File: logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

	// ======================================================================
	// opcodes and R-type function codes
	// ======================================================================
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j     = 6'h02;
	localparam logic [5:0] op_jal   = 6'h03;
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_bne   = 6'h05;
	localparam logic [5:0] op_jr    = 6'h08;
	localparam logic [5:0] op_jalr  = 6'h09;
	localparam logic [5:0] op_addi  = 6'h0a;
	localparam logic [5:0] op_andi  = 6'h0c;
	localparam logic [5:0] op_ori   = 6'h0d;
	localparam logic [5:0] op_lw    = 6'h23;
	localparam logic [5:0] op_sw    = 6'h2b;

	localparam logic [5:0] fn_sll = 6'h00;
	localparam logic [5:0] fn_srl = 6'h02;
	localparam logic [5:0] fn_add = 6'h20;
	localparam logic [5:0] fn_sub = 6'h22;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or  = 6'h25;
	localparam logic [5:0] fn_xor = 6'h26;
	localparam logic [5:0] fn_slt = 6'h2a;

	localparam logic [4:0] link_reg = 5'd31; // jal target register.

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sll,
		alu_srl
	} alu_op_t;

	// ======================================================================
	// instruction word in its three encodings
	// ======================================================================
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_form_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} i_form_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] index26;
	} j_form_t;

	typedef union packed {
		r_form_t r;
		i_form_t i;
		j_form_t j;
	} inst_t;

endpackage

`default_nettype wire

// File: logic/pipe_pkg.sv
`default_nettype none

package pipe_pkg;
	import isa_pkg::*;

	// writeback source select.
	localparam logic [1:0] wb_alu  = 2'd0;
	localparam logic [1:0] wb_load = 2'd1;
	localparam logic [1:0] wb_link = 2'd2;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
	} if_id_t;

	typedef struct packed {
		logic [31:0] rfa;
		logic [31:0] rfb;      // rt value, also store data.
		logic [31:0] opb;      // rt value or extended immediate.
		logic [4:0]  shamt;
		alu_op_t     alu_op;
		logic [4:0]  waddr;
		logic [31:0] link;
		logic        rfw;
		logic [1:0]  wbsource;
		logic        drw;
	} id_ex_t;

	typedef struct packed {
		logic [31:0] result;
		logic [31:0] sdata;
		logic [4:0]  waddr;
		logic        rfw;
		logic [1:0]  wbsource;
		logic        drw;
		logic [31:0] link;
	} ex_mem_t;

	typedef struct packed {
		logic        rfw;
		logic [4:0]  waddr;
		logic [31:0] wdata;
	} wb_t;

endpackage

`default_nettype wire

// File: logic/cpu_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch
	import pipe_pkg::*;
(
	input  wire         clk,
	input  wire         rst,
	output logic [31:0] imem_addr,
	input  wire  [31:0] imem_data,
	input  wire         branch_taken,
	input  wire         jump_taken,
	input  wire  [31:0] target,
	output if_id_t      if_id
);

	logic [31:0] pc;
	logic [31:0] pc_next;

	assign imem_addr = pc;

	// the delay slot is already being fetched when decode redirects.
	assign pc_next = (branch_taken || jump_taken) ? target : pc + 32'd4;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= 32'd0;
		end else begin
			pc <= pc_next;
		end
	end

	always_ff @(posedge clk) begin
		if_id.pc   <= pc;
		if_id.inst <= imem_data;
		if (rst)
			if_id.inst <= 32'd0; // sll r0 as nop.
	end

	assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
		else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

// File: logic/cpu_id.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_id
	import isa_pkg::*, pipe_pkg::*;
(
	input  wire         clk,
	input  wire         rst,
	input  wire if_id_t if_id,
	input  wire wb_t    wb,
	output logic        branch_taken,
	output logic        jump_taken,
	output logic [31:0] target,
	output id_ex_t      id_ex
);

	inst_t       inst;
	logic [31:0] rf [31:1];
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [31:0] pc_plus4;
	logic [31:0] imm_ext;
	logic [31:0] br_target;
	logic [31:0] jmp_target;
	alu_op_t     alu_op;
	logic        rfw;
	logic        drw;
	logic        use_imm;
	logic        zero_ext;
	logic [1:0]  wbsource;
	logic [4:0]  waddr;

	assign inst = if_id.inst;

	// ======================================================================
	// register file
	// ======================================================================
	assign rs_val = (inst.r.rs == 5'd0) ? 32'd0 : rf[inst.r.rs];
	assign rt_val = (inst.r.rt == 5'd0) ? 32'd0 : rf[inst.r.rt];

	always_ff @(posedge clk) begin
		if (wb.rfw && wb.waddr != 5'd0)
			rf[wb.waddr] <= wb.wdata;
	end

	// ======================================================================
	// control decode
	// ======================================================================
	always_comb begin
		alu_op   = alu_add;
		rfw      = 1'b0;
		drw      = 1'b0;
		use_imm  = 1'b1;
		zero_ext = 1'b0;
		wbsource = wb_alu;
		waddr    = inst.i.rt;
		case (inst.r.opcode)
			op_rtype: begin
				use_imm = 1'b0;
				rfw     = 1'b1;
				waddr   = inst.r.rd;
				case (inst.r.funct)
					fn_add:  alu_op = alu_add;
					fn_sub:  alu_op = alu_sub;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_xor:  alu_op = alu_xor;
					fn_slt:  alu_op = alu_slt;
					fn_sll:  alu_op = alu_sll;
					fn_srl:  alu_op = alu_srl;
					default: rfw = 1'b0; // unknown funct is a nop.
				endcase
			end
			op_addi: rfw = 1'b1;
			op_andi: begin
				rfw      = 1'b1;
				alu_op   = alu_and;
				zero_ext = 1'b1;
			end
			op_ori: begin
				rfw      = 1'b1;
				alu_op   = alu_or;
				zero_ext = 1'b1;
			end
			op_lw: begin
				rfw      = 1'b1;
				wbsource = wb_load;
			end
			op_sw: drw = 1'b1;
			op_jal: begin
				rfw      = 1'b1;
				waddr    = link_reg;
				wbsource = wb_link;
			end
			op_jalr: begin
				rfw      = 1'b1;
				wbsource = wb_link; // links to rt.
			end
			default: ;
		endcase
	end

	assign imm_ext = zero_ext ? {16'd0, inst.i.imm16} : {{16{inst.i.imm16[15]}}, inst.i.imm16};

	// ======================================================================
	// branch and jump resolution
	// ======================================================================
	assign pc_plus4  = if_id.pc + 32'd4;
	assign br_target = pc_plus4 + {{14{inst.i.imm16[15]}}, inst.i.imm16, 2'b00};

	always_comb begin
		if (inst.j.opcode == op_jr || inst.j.opcode == op_jalr)
			jmp_target = rs_val;
		else
			jmp_target = {pc_plus4[31:28], inst.j.index26, 2'b00};
	end

	assign branch_taken = (inst.i.opcode == op_beq && rs_val == rt_val) ||
		(inst.i.opcode == op_bne && rs_val != rt_val);
	assign jump_taken = inst.j.opcode == op_j || inst.j.opcode == op_jal ||
		inst.j.opcode == op_jr || inst.j.opcode == op_jalr;
	assign target = jump_taken ? jmp_target : br_target;

	// ======================================================================
	// decode/execute register
	// ======================================================================
	always_ff @(posedge clk) begin
		id_ex.rfa      <= rs_val;
		id_ex.rfb      <= rt_val;
		id_ex.opb      <= use_imm ? imm_ext : rt_val;
		id_ex.shamt    <= inst.r.shamt;
		id_ex.alu_op   <= alu_op;
		id_ex.waddr    <= waddr;
		id_ex.link     <= if_id.pc + 32'd8; // past the delay slot.
		id_ex.rfw      <= rfw && waddr != 5'd0; // r0 writes retire nothing.
		id_ex.wbsource <= wbsource;
		id_ex.drw      <= drw;
		if (rst) begin
			id_ex.rfw <= 1'b0;
			id_ex.drw <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (rst) !(branch_taken && jump_taken))
		else $error("branch and jump taken together at pc %h", if_id.pc);

endmodule

`default_nettype wire

// File: logic/cpu_ex.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_ex
	import isa_pkg::*, pipe_pkg::*;
(
	input  wire         clk,
	input  wire         rst,
	input  wire id_ex_t id_ex,
	output ex_mem_t     ex_mem
);

	logic [31:0] result;

	// ======================================================================
	// ALU
	// ======================================================================
	always_comb begin
		case (id_ex.alu_op)
			alu_add: result = id_ex.rfa + id_ex.opb; // also load/store address.
			alu_sub: result = id_ex.rfa - id_ex.opb;
			alu_and: result = id_ex.rfa & id_ex.opb;
			alu_or:  result = id_ex.rfa | id_ex.opb;
			alu_xor: result = id_ex.rfa ^ id_ex.opb;
			alu_slt: result = {31'd0, $signed(id_ex.rfa) < $signed(id_ex.opb)};
			alu_sll: result = id_ex.opb << id_ex.shamt;
			alu_srl: result = id_ex.opb >> id_ex.shamt;
			default: result = 32'd0;
		endcase
	end

	// ======================================================================
	// execute/memory register
	// ======================================================================
	always_ff @(posedge clk) begin
		ex_mem.result   <= result;
		ex_mem.sdata    <= id_ex.rfb;
		ex_mem.waddr    <= id_ex.waddr;
		ex_mem.rfw      <= id_ex.rfw;
		ex_mem.wbsource <= id_ex.wbsource;
		ex_mem.drw      <= id_ex.drw;
		ex_mem.link     <= id_ex.link;
		if (rst) begin
			ex_mem.rfw <= 1'b0;
			ex_mem.drw <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: logic/cpu_mem.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_mem
	import pipe_pkg::*;
(
	input  wire          clk,
	input  wire          rst,
	input  wire ex_mem_t ex_mem,
	output logic [31:0]  dmem_addr,
	output logic [31:0]  dmem_wdata,
	output logic         dmem_we,
	input  wire  [31:0]  dmem_rdata,
	output wb_t          wb
);

	logic [31:0] wdata;

	// data port is a plain combinational read with a write strobe.
	assign dmem_addr  = ex_mem.result;
	assign dmem_wdata = ex_mem.sdata;
	assign dmem_we    = ex_mem.drw;

	always_comb begin
		case (ex_mem.wbsource)
			wb_load: wdata = dmem_rdata;
			wb_link: wdata = ex_mem.link;
			default: wdata = ex_mem.result;
		endcase
	end

	always_ff @(posedge clk) begin
		wb.rfw   <= ex_mem.rfw;
		wb.waddr <= ex_mem.waddr;
		wb.wdata <= wdata;
		if (rst)
			wb.rfw <= 1'b0;
	end

	assert property (@(posedge clk) disable iff (rst) !(ex_mem.drw && ex_mem.rfw))
		else $error("store also requests write to r%0d", ex_mem.waddr);

endmodule

`default_nettype wire

// File: logic/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top
	import pipe_pkg::*;
(
	input  wire         clk,
	input  wire         rst,
	output logic [31:0] imem_addr,
	input  wire  [31:0] imem_data,
	output logic [31:0] dmem_addr,
	output logic [31:0] dmem_wdata,
	output logic        dmem_we,
	input  wire  [31:0] dmem_rdata,
	output wb_t         retire
);

	if_id_t      if_id;
	id_ex_t      id_ex;
	ex_mem_t     ex_mem;
	logic        branch_taken;
	logic        jump_taken;
	logic [31:0] target;

	cpu_fetch fetch0 (
		.clk          (clk),
		.rst          (rst),
		.imem_addr    (imem_addr),
		.imem_data    (imem_data),
		.branch_taken (branch_taken),
		.jump_taken   (jump_taken),
		.target       (target),
		.if_id        (if_id)
	);

	cpu_id id0 (
		.clk          (clk),
		.rst          (rst),
		.if_id        (if_id),
		.wb           (retire), // writeback bus doubles as retire record.
		.branch_taken (branch_taken),
		.jump_taken   (jump_taken),
		.target       (target),
		.id_ex        (id_ex)
	);

	cpu_ex ex0 (
		.clk    (clk),
		.rst    (rst),
		.id_ex  (id_ex),
		.ex_mem (ex_mem)
	);

	cpu_mem mem0 (
		.clk        (clk),
		.rst        (rst),
		.ex_mem     (ex_mem),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_rdata (dmem_rdata),
		.wb         (retire)
	);

endmodule

`default_nettype wire

// File: tb/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker
	import isa_pkg::*, pipe_pkg::*;
(
	input  wire         clk,
	input  wire         rst,
	input  wire         done,
	input  wire  [31:0] imem_addr,
	input  wire  [31:0] imem_data,
	input  wire  [31:0] dmem_addr,
	input  wire  [31:0] dmem_wdata,
	input  wire         dmem_we,
	input  wire wb_t    retire,
	output int          fetch_errs,
	output int          store_errs,
	output int          retire_errs
);

	logic [31:0] regs [0:31];
	logic [31:0] mem [0:63];
	logic [31:0] pc;
	logic [31:0] npc;
	logic [36:0] exp_retire [$]; // {waddr, wdata}.
	logic [63:0] exp_store [$];  // {addr, data}.
	int          retire_due [$]; // cycle each retire is expected in.
	int          store_due [$];
	int          cycle;
	logic        reported;

	// ======================================================================
	// ISA model that executes one instruction per fetch with a delay slot
	// ======================================================================
	task automatic execute(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] se;
		logic [31:0] ze;
		logic [31:0] val;
		logic [31:0] next;
		logic [31:0] p4;
		logic [4:0]  dst;
		logic        wr;
		a    = regs[w[25:21]];
		b    = regs[w[20:16]];
		se   = {{16{w[15]}}, w[15:0]};
		ze   = {16'd0, w[15:0]};
		next = npc + 32'd4;
		p4   = pc + 32'd4;
		wr   = 1'b1;
		dst  = w[20:16];
		val  = 32'd0;
		case (w[31:26])
			op_rtype: begin
				dst = w[15:11];
				case (w[5:0])
					fn_add:  val = a + b;
					fn_sub:  val = a - b;
					fn_and:  val = a & b;
					fn_or:   val = a | b;
					fn_xor:  val = a ^ b;
					fn_slt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					fn_sll:  val = b << w[10:6];
					fn_srl:  val = b >> w[10:6];
					default: wr = 1'b0;
				endcase
			end
			op_addi: val = a + se;
			op_andi: val = a & ze;
			op_ori:  val = a | ze;
			op_lw:   val = mem[(a + se) >> 2 & 32'h3f];
			op_sw: begin
				wr = 1'b0;
				exp_store.push_back({a + se, b});
				store_due.push_back(cycle + 3);
				mem[(a + se) >> 2 & 32'h3f] = b;
			end
			op_beq, op_bne: begin
				wr = 1'b0;
				if ((a == b) == (w[31:26] == op_beq))
					next = p4 + (se << 2);
			end
			op_j, op_jal: begin
				next = {p4[31:28], w[25:0], 2'b00};
				wr   = w[31:26] == op_jal;
				dst  = 5'd31;
				val  = pc + 32'd8;
			end
			op_jr: begin
				wr   = 1'b0;
				next = a;
			end
			op_jalr: begin
				next = a;
				val  = pc + 32'd8; // links to rt.
			end
			default: wr = 1'b0;
		endcase
		if (wr && dst != 5'd0) begin
			regs[dst] = val;
			exp_retire.push_back({dst, val});
			retire_due.push_back(cycle + 4);
		end
		pc  = npc;
		npc = next;
	endtask

	always @(posedge clk) begin
		logic [36:0] er;
		logic [63:0] es;
		int          due;
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] = 32'd0;
			for (int i = 0; i < 64; i++)
				mem[i] = 32'hd000_0000 ^ (32'(i) * 32'h0001_0003);
			pc  = 32'd0;
			npc = 32'd4;
			exp_retire.delete();
			exp_store.delete();
			retire_due.delete();
			store_due.delete();
			cycle       = 0;
			fetch_errs  = 0;
			store_errs  = 0;
			retire_errs = 0;
			reported    = 1'b0;
		end else begin
			if (imem_addr !== pc) begin
				$display("FAILED imem_addr: expected %h, got %h", pc, imem_addr);
				fetch_errs++;
			end
			execute(imem_data);
			if (retire.rfw !== 1'b0) begin
				if (exp_retire.size() == 0) begin
					$display("retire to r%0d seen with no instruction pending", retire.waddr);
					retire_errs++;
				end else begin
					er  = exp_retire.pop_front();
					due = retire_due.pop_front();
					if (due != cycle) begin
						$display("retire to r%0d came in cycle %0d, expected in cycle %0d",
							retire.waddr, cycle, due);
						retire_errs++;
					end
					if ({retire.waddr, retire.wdata} !== er) begin
						$display("FAILED retire.waddr/wdata: expected %h/%h, got %h/%h",
							er[36:32], er[31:0], retire.waddr, retire.wdata);
						retire_errs++;
					end
				end
			end
			while (retire_due.size() != 0 && retire_due[0] <= cycle) begin
				er  = exp_retire.pop_front();
				due = retire_due.pop_front();
				$display("retire to r%0d due in cycle %0d never appeared", er[36:32], due);
				retire_errs++;
			end
			if (dmem_we !== 1'b0) begin
				if (exp_store.size() == 0) begin
					$display("store to %h seen with no store pending", dmem_addr);
					store_errs++;
				end else begin
					es  = exp_store.pop_front();
					due = store_due.pop_front();
					if (due != cycle) begin
						$display("store to %h came in cycle %0d, expected in cycle %0d",
							dmem_addr, cycle, due);
						store_errs++;
					end
					if ({dmem_addr, dmem_wdata} !== es) begin
						$display("FAILED dmem_addr/dmem_wdata: expected %h/%h, got %h/%h",
							es[63:32], es[31:0], dmem_addr, dmem_wdata);
						store_errs++;
					end
				end
			end
			while (store_due.size() != 0 && store_due[0] <= cycle) begin
				es  = exp_store.pop_front();
				due = store_due.pop_front();
				$display("store to %h due in cycle %0d never appeared", es[63:32], due);
				store_errs++;
			end
			if (done && !reported) begin
				reported = 1'b1;
				if (exp_retire.size() != 0)
					$display("%0d expected retires never appeared", exp_retire.size());
				if (exp_store.size() != 0)
					$display("%0d expected stores never appeared", exp_store.size());
				retire_errs += exp_retire.size();
				store_errs  += exp_store.size();
			end
			cycle++;
		end
	end

endmodule

`default_nettype wire

// File: tb/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb
	import isa_pkg::*, pipe_pkg::*;
();

	localparam int prog_len  = 300;
	localparam int run_limit = prog_len * 4 + 100; // cycles.

	logic        clk;
	logic        rst;
	logic        done;
	logic [31:0] imem_data;
	logic [31:0] dmem_rdata;
	logic [31:0] imem_addr;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic        dmem_we;
	wb_t         retire;
	int          fetch_errs;
	int          store_errs;
	int          retire_errs;

	logic [31:0] imem [0:1023];
	logic [31:0] dmem [0:63];
	logic [31:0] seed;
	logic [4:0]  recent [0:2]; // destinations of the last three instructions.
	int          n;
	int          end_word;

	cpu_top dut0 (
		.clk        (clk),
		.rst        (rst),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_rdata (dmem_rdata),
		.retire     (retire)
	);

	cpu_checker chk0 (
		.clk         (clk),
		.rst         (rst),
		.done        (done),
		.imem_addr   (imem_addr),
		.imem_data   (imem_data),
		.dmem_addr   (dmem_addr),
		.dmem_wdata  (dmem_wdata),
		.dmem_we     (dmem_we),
		.retire      (retire),
		.fetch_errs  (fetch_errs),
		.store_errs  (store_errs),
		.retire_errs (retire_errs)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// ======================================================================
	// program generator
	// ======================================================================
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw(output logic [31:0] r);
		seed = xorshift(seed);
		r    = seed;
	endtask

	task automatic put(input logic [31:0] w, input logic [4:0] dest);
		imem[n]   = w;
		recent[2] = recent[1];
		recent[1] = recent[0];
		recent[0] = dest;
		n = n + 1;
	endtask

	task automatic pad(input int k);
		for (int i = 0; i < k; i++)
			put(32'd0, 5'd0); // sll r0 is a nop.
	endtask

	// a source written in the last three instructions falls back to r0.
	task automatic pick_src(output logic [4:0] r);
		logic [31:0] v;
		draw(v);
		r = v[4:0];
		if (r == recent[0] || r == recent[1] || r == recent[2])
			r = 5'd0;
	endtask

	task automatic random_op();
		logic [31:0] v;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [5:0]  fn;
		draw(v);
		pick_src(rs);
		pick_src(rt);
		rd = v[12:8]; // r0 shows up now and then.
		case (v[2:0])
			3'd0: fn = fn_add;
			3'd1: fn = fn_sub;
			3'd2: fn = fn_and;
			3'd3: fn = fn_or;
			3'd4: fn = fn_xor;
			3'd5: fn = fn_slt;
			3'd6: fn = fn_sll;
			default: fn = fn_srl;
		endcase
		case (v[7:4])
			4'd8:  put({op_addi, rs, rd, v[31:16]}, rd);
			4'd9:  put({op_andi, rs, rd, v[31:16]}, rd);
			4'd10: put({op_ori, rs, rd, v[31:16]}, rd);
			4'd11, 4'd12: put({op_lw, 5'd0, rd, 8'd0, v[21:16], 2'b00}, rd);
			4'd13, 4'd14: put({op_sw, 5'd0, rt, 8'd0, v[21:16], 2'b00}, 5'd0);
			default: put({op_rtype, rs, rt, rd, v[20:16], fn}, rd);
		endcase
	endtask

	// nops around the slot and the target keep every path hazard free.
	task automatic control_block();
		logic [31:0] v;
		logic [4:0]  rs;
		logic [4:0]  rt;
		int          br_at;
		int          skip;
		int          tgt;
		draw(v);
		pad(3);
		pick_src(rs);
		pick_src(rt);
		if (v[10])
			rt = rs;
		skip  = 1 + int'(v[9:8]);
		br_at = (v[2:0] == 3'd4 || v[2:0] == 3'd5) ? n + 4 : n;
		tgt   = br_at + 5 + skip;
		case (v[2:0])
			3'd2: put({op_j, 26'(tgt)}, 5'd0);
			3'd3: put({op_jal, 26'(tgt)}, link_reg);
			3'd4, 3'd5: begin
				rs = (v[15:11] == 5'd0) ? 5'd1 : v[15:11];
				put({op_addi, 5'd0, rs, 16'(tgt * 4)}, rs);
				pad(3);
				if (v[0])
					put({op_jalr, rs, v[20:16], 16'd0}, v[20:16]);
				else
					put({op_jr, rs, 5'd0, 16'd0}, 5'd0);
			end
			3'd1, 3'd7: put({op_bne, rs, rt, 16'(tgt - br_at - 1)}, 5'd0);
			default: put({op_beq, rs, rt, 16'(tgt - br_at - 1)}, 5'd0);
		endcase
		pad(4);
		for (int i = 0; i < skip; i++)
			random_op();
		pad(3);
	endtask

	task automatic build_program();
		logic [31:0] v;
		seed = 32'd71;
		n    = 0;
		for (int i = 0; i < 3; i++)
			recent[i] = 5'd0;
		for (int i = 0; i < 1024; i++)
			imem[i] = 32'd0;
		for (int r = 1; r < 32; r++) begin
			draw(v);
			put({op_addi, 5'd0, 5'(r), v[15:0]}, 5'(r));
		end
		pad(3);
		while (n < 275) begin
			draw(v);
			if (v[2:0] == 3'd0)
				control_block();
			else
				random_op();
		end
		pad(3);
		end_word = n;
		put({op_j, 26'(n)}, 5'd0); // spin here.
		put(32'd0, 5'd0);
	endtask

	// ======================================================================
	// memories driven on the falling edge
	// ======================================================================
	always @(negedge clk) begin
		imem_data  <= imem[imem_addr[11:2]];
		dmem_rdata <= dmem[dmem_addr[7:2]];
	end

	always @(posedge clk) begin
		if (!rst && dmem_we)
			dmem[dmem_addr[7:2]] <= dmem_wdata;
	end

	initial begin
		rst        = 1'b1;
		done       = 1'b0;
		imem_data  = 32'd0;
		dmem_rdata = 32'd0;
		for (int i = 0; i < 64; i++)
			dmem[i] = 32'hd000_0000 ^ (32'(i) * 32'h0001_0003);
		build_program();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (imem_addr !== 32'(end_word * 4))
			@(negedge clk);
		repeat (6) @(posedge clk); // drain the pipeline.
		@(negedge clk);
		done = 1'b1;
		repeat (2) @(negedge clk);
		$display("errors: fetch %0d store %0d retire %0d", fetch_errs, store_errs, retire_errs);
		if (fetch_errs + store_errs + retire_errs == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial begin
		repeat (run_limit) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", run_limit);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: cpu_top.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/cpu_fetch.sv
logic/cpu_id.sv
logic/cpu_ex.sv
logic/cpu_mem.sv
logic/cpu_top.sv
tb/cpu_checker.sv
tb/cpu_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = cpu_tb
FILELIST  = cpu_top.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
